/* design/cpu_pkg.sv */
/*
    CPU core package
    Opcode and ALU function encodings, register and flag types,
    instruction field positions and fixed addresses shared by the core.
*/

package cpu_pkg;

    // instruction classes, bits 15..12 of the instruction word
    typedef enum logic [3:0] {
        OP_LD_IMM  = 4'h0,
        OP_ADD     = 4'h1,
        OP_SUB     = 4'h2,
        OP_AND     = 4'h3,
        OP_OR      = 4'h4,
        OP_XOR     = 4'h5,
        OP_MOV     = 4'h6,
        OP_ADD_IMM = 4'h7,
        OP_ST      = 4'h8,
        OP_JR_Z    = 4'h9,
        OP_JR_NZ   = 4'ha,
        OP_HALT    = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_IMM = 3'd0,
        ALU_ADD      = 3'd1,
        ALU_SUB      = 3'd2,
        ALU_AND      = 3'd3,
        ALU_OR       = 3'd4,
        ALU_XOR      = 3'd5,
        ALU_PASS_SRC = 3'd6
    } alu_op_t;

    typedef logic [2:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // z sits in bit 0, c in bit 1
    typedef struct packed {
        logic c;
        logic z;
    } flags_t;

    // instruction word fields
    localparam int OPC_HI = 15;
    localparam int OPC_LO = 12;
    localparam int DST_HI = 11;
    localparam int DST_LO = 9;
    localparam int SRC_HI = 8;
    localparam int SRC_LO = 6;
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;

    localparam logic [23:0] PC_RSTVAL = 24'h000000;
    localparam logic [23:0] DATA_BASE = 24'h001000;
    // dump address of the flag byte, right after the 32 register bytes
    localparam logic [7:0]  DMP_FLAGS = 8'd32;

endpackage

/* design/cpu_ifs.sv */
/*
    Core internal interfaces
    exec_if carries a decoded instruction into the ALU, res_if carries
    the ALU outcome into the result stage.
*/

interface exec_if import cpu_pkg::*; ();
    alu_op_t    alu_op;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    reg_idx_t   dst;
    logic       wr_en;
    logic       flag_we;
    logic       st_en;
    logic [7:0] st_off;

    modport source (
        output alu_op, op_a, op_b, imm, dst, wr_en, flag_we, st_en, st_off
    );
    modport sink (
        input  alu_op, op_a, op_b, imm, dst, wr_en, flag_we, st_en, st_off
    );
endinterface

interface res_if import cpu_pkg::*; ();
    word_t       result;
    flags_t      nx_flags;
    reg_idx_t    dst;
    logic        wr_en;
    logic        flag_we;
    logic        st_en;
    logic [15:0] st_data;
    logic [7:0]  st_off;

    modport source (
        output result, nx_flags, dst, wr_en, flag_we, st_en, st_data, st_off
    );
    modport sink (
        input  result, nx_flags, dst, wr_en, flag_we, st_en, st_data, st_off
    );
endinterface

/* design/cpu_regs.sv */
/*
    Register file
    Eight 32-bit registers with two read ports and one write port,
    plus the byte-wide dump read of registers and flags.
*/

module cpu_regs import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  reg_idx_t   rd_a,
    input  reg_idx_t   rd_b,
    output word_t      rd_a_data,
    output word_t      rd_b_data,
    input  logic       wr_en,
    input  reg_idx_t   wr_idx,
    input  word_t      wr_data,
    input  flags_t     flags,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_dout
);

    word_t regs [8];
    word_t dmp_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (cen && wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_a_data = regs[rd_a];
    assign rd_b_data = regs[rd_b];

    // register number in dmp_addr[4:2], byte lane in [1:0]
    assign dmp_word = regs[dmp_addr[4:2]];

    always_comb begin
        if (dmp_addr < 8'd32) begin
            case (dmp_addr[1:0])
                2'd0:    dmp_dout = dmp_word[7:0];
                2'd1:    dmp_dout = dmp_word[15:8];
                2'd2:    dmp_dout = dmp_word[23:16];
                default: dmp_dout = dmp_word[31:24];
            endcase
        end else if (dmp_addr == DMP_FLAGS) begin
            dmp_dout = {6'd0, flags};
        end else begin
            dmp_dout = 8'd0;
        end
    end

endmodule

/* design/cpu_alu.sv */
/*
    Execute stage
    Computes the ALU result and the next flags and registers them,
    together with the write and store strobes, for the result stage.
*/

module cpu_alu import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    input  flags_t flags,
    exec_if.sink   ex,
    res_if.source  res
);

    logic [32:0] sum;
    logic [32:0] diff;
    word_t       result;
    flags_t      nx_flags;

    assign sum  = {1'b0, ex.op_a} + {1'b0, ex.op_b};
    assign diff = {1'b0, ex.op_a} - {1'b0, ex.op_b};

    always_comb begin
        result   = ex.op_b;
        nx_flags = flags;
        case (ex.alu_op)
            ALU_PASS_IMM: result = ex.imm;
            ALU_ADD: begin
                result     = sum[31:0];
                nx_flags.c = sum[32];
            end
            ALU_SUB: begin
                result     = diff[31:0];
                // bit 32 of the difference is the borrow
                nx_flags.c = diff[32];
            end
            ALU_AND: begin
                result     = ex.op_a & ex.op_b;
                nx_flags.c = 1'b0;
            end
            ALU_OR: begin
                result     = ex.op_a | ex.op_b;
                nx_flags.c = 1'b0;
            end
            ALU_XOR: begin
                result     = ex.op_a ^ ex.op_b;
                nx_flags.c = 1'b0;
            end
            default: result = ex.op_b;
        endcase
        // pass operations keep z as well
        if (ex.alu_op != ALU_PASS_IMM && ex.alu_op != ALU_PASS_SRC) begin
            nx_flags.z = (result == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.wr_en   <= 1'b0;
            res.flag_we <= 1'b0;
            res.st_en   <= 1'b0;
        end else if (cen) begin
            res.wr_en   <= ex.wr_en;
            res.flag_we <= ex.flag_we;
            res.st_en   <= ex.st_en;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            res.result   <= result;
            res.nx_flags <= nx_flags;
            res.dst      <= ex.dst;
            res.st_data  <= ex.op_a[15:0];
            res.st_off   <= ex.st_off;
        end
    end

    a_clean_result: assert property (@(posedge clk) disable iff (rst)
        res.wr_en |-> !$isunknown(res.result));

endmodule

/* design/cpu_result.sv */
/*
    Result stage
    Holds the flag register, forwards register writes and
    turns store requests into bus writes in the data region.
*/

module cpu_result import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    res_if.sink         res,
    output logic        wr_en,
    output reg_idx_t    wr_idx,
    output word_t       wr_data,
    output flags_t      flags,
    output logic [23:0] st_addr,
    output logic [15:0] st_data,
    output logic [1:0]  st_we
);

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (cen && res.flag_we) begin
            flags <= res.nx_flags;
        end
    end

    assign wr_en   = res.wr_en;
    assign wr_idx  = res.dst;
    assign wr_data = res.result;

    // word offset into the data region
    assign st_addr = DATA_BASE + {15'd0, res.st_off, 1'b0};
    assign st_data = res.st_data;
    assign st_we   = res.st_en ? 2'd3 : 2'd0;

    a_store_or_write: assert property (@(posedge clk) disable iff (rst)
        !(st_we != 2'd0 && wr_en));

endmodule

/* design/cpu_decode.sv */
/*
    Instruction sequencer and decoder
    Runs the fetch/decode/execute/result cycle, keeps the program counter,
    splits the instruction word and resolves relative jumps.
*/

module cpu_decode import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [15:0] din,
    output logic [23:0] pc_addr,
    input  flags_t      flags,
    output reg_idx_t    rd_a,
    output reg_idx_t    rd_b,
    input  word_t       rd_a_data,
    input  word_t       rd_b_data,
    exec_if.source      ex,
    output logic        halted
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_RESULT, S_HALT
    } state_t;

    state_t      state;
    logic [23:0] pc;
    logic [15:0] ir;
    opcode_t     opc;
    logic [7:0]  imm8;
    word_t       imm_ext;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        do_wr;
    logic        do_st;
    logic        in_exec;
    logic        taken;
    logic [23:0] pc_seq;
    logic [23:0] pc_tgt;

    assign opc     = opcode_t'(ir[OPC_HI:OPC_LO]);
    assign imm8    = ir[IMM_HI:IMM_LO];
    assign imm_ext = {24'd0, imm8};
    assign rd_a    = ir[DST_HI:DST_LO];
    assign rd_b    = ir[SRC_HI:SRC_LO];
    assign in_exec = (state == S_EXEC);

    always_comb begin
        alu_op  = ALU_PASS_SRC;
        use_imm = 1'b0;
        do_wr   = 1'b0;
        do_st   = 1'b0;
        case (opc)
            OP_LD_IMM: begin
                alu_op = ALU_PASS_IMM;
                do_wr  = 1'b1;
            end
            OP_ADD: begin
                alu_op = ALU_ADD;
                do_wr  = 1'b1;
            end
            OP_SUB: begin
                alu_op = ALU_SUB;
                do_wr  = 1'b1;
            end
            OP_AND: begin
                alu_op = ALU_AND;
                do_wr  = 1'b1;
            end
            OP_OR: begin
                alu_op = ALU_OR;
                do_wr  = 1'b1;
            end
            OP_XOR: begin
                alu_op = ALU_XOR;
                do_wr  = 1'b1;
            end
            OP_MOV: begin
                alu_op = ALU_PASS_SRC;
                do_wr  = 1'b1;
            end
            OP_ADD_IMM: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                do_wr   = 1'b1;
            end
            OP_ST:   do_st = 1'b1;
            default: ;
        endcase
    end

    // the ALU keeps the flags itself for the pass operations
    assign ex.alu_op  = alu_op;
    assign ex.op_a    = rd_a_data;
    assign ex.op_b    = use_imm ? imm_ext : rd_b_data;
    assign ex.imm     = imm_ext;
    assign ex.dst     = rd_a;
    assign ex.wr_en   = in_exec & do_wr;
    assign ex.flag_we = in_exec & do_wr;
    assign ex.st_en   = in_exec & do_st;
    assign ex.st_off  = imm8;

    // jump offset counts words
    assign taken  = (opc == OP_JR_Z && flags.z) || (opc == OP_JR_NZ && !flags.z);
    assign pc_seq = pc + 24'd2;
    assign pc_tgt = pc_seq + {{15{imm8[7]}}, imm8, 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FETCH;
            pc    <= PC_RSTVAL;
        end else if (cen) begin
            case (state)
                S_FETCH:  state <= S_DECODE;
                S_DECODE: state <= S_EXEC;
                S_EXEC:   state <= S_RESULT;
                S_RESULT: begin
                    if (opc == OP_HALT) begin
                        state <= S_HALT;
                    end else begin
                        state <= S_FETCH;
                        pc    <= taken ? pc_tgt : pc_seq;
                    end
                end
                default:  state <= S_HALT;
            endcase
        end
    end

    // memory data is valid one enabled cycle after the fetch address
    always_ff @(posedge clk) begin
        if (cen && state == S_DECODE) begin
            ir <= din;
        end
    end

    assign pc_addr = pc;
    assign halted  = (state == S_HALT);

    // halt state and program counter hold until reset
    a_halt_holds: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted && $stable(pc));

endmodule

/* design/cpu_top.sv */
/*
    CPU core top level
    Joins sequencer, register file, ALU and result stage, and
    drives the 16-bit bus shared by instruction fetch and stores.
*/

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    output logic [23:0] addr,
    input  logic [15:0] din,
    output logic [15:0] dout,
    output logic [1:0]  we,
    output logic        halted,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout
);

    logic [23:0] pc_addr;
    logic [23:0] st_addr;
    logic [15:0] st_data;
    logic [1:0]  st_we;
    flags_t      flags;
    reg_idx_t    rd_a;
    reg_idx_t    rd_b;
    word_t       rd_a_data;
    word_t       rd_b_data;
    logic        wr_en;
    reg_idx_t    wr_idx;
    word_t       wr_data;

    exec_if ex_bus ();
    res_if  res_bus ();

    cpu_decode u_decode (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cen       ( cen       ),
        .din       ( din       ),
        .pc_addr   ( pc_addr   ),
        .flags     ( flags     ),
        .rd_a      ( rd_a      ),
        .rd_b      ( rd_b      ),
        .rd_a_data ( rd_a_data ),
        .rd_b_data ( rd_b_data ),
        .ex        ( ex_bus    ),
        .halted    ( halted    )
    );

    cpu_regs u_regs (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cen       ( cen       ),
        .rd_a      ( rd_a      ),
        .rd_b      ( rd_b      ),
        .rd_a_data ( rd_a_data ),
        .rd_b_data ( rd_b_data ),
        .wr_en     ( wr_en     ),
        .wr_idx    ( wr_idx    ),
        .wr_data   ( wr_data   ),
        .flags     ( flags     ),
        .dmp_addr  ( dmp_addr  ),
        .dmp_dout  ( dmp_dout  )
    );

    cpu_alu u_alu (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .cen   ( cen     ),
        .flags ( flags   ),
        .ex    ( ex_bus  ),
        .res   ( res_bus )
    );

    cpu_result u_result (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .cen     ( cen     ),
        .res     ( res_bus ),
        .wr_en   ( wr_en   ),
        .wr_idx  ( wr_idx  ),
        .wr_data ( wr_data ),
        .flags   ( flags   ),
        .st_addr ( st_addr ),
        .st_data ( st_data ),
        .st_we   ( st_we   )
    );

    // a pending store owns the bus, otherwise the program counter
    assign addr = (st_we != 2'd0) ? st_addr : pc_addr;
    assign dout = st_data;
    assign we   = st_we;

endmodule

/* tests/tb_cpu.sv */
/*
    Testbench for the CPU core
    Runs every program of the pattern file twice, once with cen held high
    and once with cen from an LFSR, and checks stores and the register dump.
*/

module tb_cpu import cpu_pkg::*; ();

    typedef enum logic [1:0] {CEN_LOW, CEN_HIGH, CEN_RANDOM} cen_mode_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    logic [23:0] addr;
    logic [15:0] din;
    logic [15:0] dout;
    logic [1:0]  we;
    logic        halted;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;

    logic [31:0] pat [256];
    logic [15:0] mem [32768];
    logic [15:0] lfsr;
    logic        last_cen;
    logic [23:0] last_addr;
    int          st_base;
    int          st_count;
    int          st_seen;
    int          cycles = 0;
    int          cycle_limit = 200;

    cpu_top DUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .addr     ( addr     ),
        .din      ( din      ),
        .dout     ( dout     ),
        .we       ( we       ),
        .halted   ( halted   ),
        .dmp_addr ( dmp_addr ),
        .dmp_dout ( dmp_dout )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a program never raised halted", cycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic word_check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic flags_check(input string name, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = c%b z%b, expected c%b z%b",
                                      $time, name, got.c, got.z, exp.c, exp.z));
        end
    endtask

    task automatic addr_check(input string name, input logic [23:0] got,
                              input logic [23:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic data_check(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic we_check(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = %0d, expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic level_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERROR at time %0t: %s = %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    // bus write seen on the coming enabled edge
    task automatic take_store();
        if (st_seen >= st_count) begin
            stop_with_error($sformatf("store number %0d to %h was not expected",
                                      st_seen + 1, addr));
        end
        we_check("we", we, 2'd3);
        addr_check("addr", addr, pat[st_base + 2 * st_seen][23:0]);
        data_check("dout", dout, pat[st_base + 2 * st_seen + 1][15:0]);
        mem[addr[15:1]] = dout;
        st_seen++;
    endtask

    // one clock: memory answer, then cen for the next rising edge
    task automatic tick(input cen_mode_t mode);
        logic [2:0] bits;
        bits = 3'd0;
        @(negedge clk);
        if (last_cen) begin
            din = mem[last_addr[15:1]];
        end
        case (mode)
            CEN_LOW:  cen = 1'b0;
            CEN_HIGH: cen = 1'b1;
            default: begin
                // low only when all three bits are zero
                repeat (3) begin
                    lfsr = lfsr_step(lfsr);
                    bits = {bits[1:0], lfsr[0]};
                end
                cen = (bits != 3'd0);
            end
        endcase
        if (cen && we != 2'd0) begin
            take_store();
        end
        last_cen  = cen;
        last_addr = addr;
    endtask

    task automatic run_program(inout int p, input cen_mode_t mode);
        int         n_words;
        int         dmp_base;
        logic [7:0] dump [33];
        word_t      got_word;
        word_t      exp_word;
        n_words = int'(pat[p]);
        for (int i = 0; i < 32768; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < n_words; i++) begin
            mem[i] = pat[p + 1 + i][15:0];
        end
        p        = p + 1 + n_words;
        st_count = int'(pat[p]);
        st_base  = p + 1;
        st_seen  = 0;
        dmp_base = st_base + 2 * st_count;
        p        = dmp_base + 33;

        rst      = 1'b1;
        last_cen = 1'b0;
        repeat (5) tick(CEN_LOW);
        rst = 1'b0;
        // no enabled cycle yet
        we_check("we", we, 2'd0);
        level_check("halted", halted, 1'b0);
        addr_check("addr", addr, PC_RSTVAL);

        while (!halted) begin
            tick(mode);
        end
        if (st_seen != st_count) begin
            stop_with_error($sformatf("program made %0d stores, expected %0d",
                                      st_seen, st_count));
        end

        for (int a = 0; a <= 32; a++) begin
            dmp_addr = a[7:0];
            tick(CEN_LOW);
            dump[a] = dmp_dout;
        end
        // register bytes come little end first
        for (int r = 0; r < 8; r++) begin
            got_word = {dump[4 * r + 3], dump[4 * r + 2], dump[4 * r + 1], dump[4 * r]};
            exp_word = {pat[dmp_base + 4 * r + 3][7:0], pat[dmp_base + 4 * r + 2][7:0],
                        pat[dmp_base + 4 * r + 1][7:0], pat[dmp_base + 4 * r][7:0]};
            word_check($sformatf("r%0d", r), got_word, exp_word);
        end
        flags_check("flags", flags_t'(dump[32][1:0]), flags_t'(pat[dmp_base + 32][1:0]));
        if (dump[32][7:2] != 6'd0) begin
            stop_with_error("flag dump byte has bits set above bit 1");
        end
    endtask

    initial begin
        int        p;
        int        total_words;
        int        n_prog;
        cen_mode_t mode;
        rst       = 1'b1;
        cen       = 1'b0;
        din       = '0;
        dmp_addr  = '0;
        lfsr      = 16'd58876;
        last_cen  = 1'b0;
        last_addr = '0;
        st_base   = 0;
        st_count  = 0;
        st_seen   = 0;
        $readmemh("tests/cpu_patterns.txt", pat);

        // program lengths set the cycle limit
        p           = 0;
        total_words = 0;
        n_prog      = 0;
        while (p < 256 && pat[p] != 32'd0) begin
            total_words += int'(pat[p]);
            p += int'(pat[p]) + 1;
            p += 2 * int'(pat[p]) + 1 + 33;
            n_prog++;
        end
        if (n_prog == 0) begin
            stop_with_error("no programs found in tests/cpu_patterns.txt");
        end
        // every program runs twice
        cycle_limit = 8 * 4 * 2 * total_words + 200;

        for (int round = 0; round < 2; round++) begin
            mode = (round == 0) ? CEN_HIGH : CEN_RANDOM;
            p    = 0;
            while (p < 256 && pat[p] != 32'd0) begin
                run_program(p, mode);
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* tests/cpu_patterns.txt */
// per program: word count, program words, store count, store address and data pairs,
// then 33 dump bytes (r0..r7 little end first, then the flag byte); a 0 count ends the list
// load, move and logic operations
e
02a5 043c 6640 6840 3880 6a40 4a80 6c40 5c80 8800 8c03 5640 0eff f000
2
001000 0024  001006 0099
00 00 00 00  a5 00 00 00  3c 00 00 00  00 00 00 00
24 00 00 00  bd 00 00 00  99 00 00 00  ff 00 00 00
01
// borrow, carry out of 32 bits, immediate add
d
0201 0402 2280 8210 6c40 6640 7601 8601 0880 78f0 88ff 1280 f000
3
001020 ffff  001002 0000  0011fe 0170
00 00 00 00  01 00 00 00  02 00 00 00  00 00 00 00
70 01 00 00  00 00 00 00  ff ff ff ff  00 00 00 00
02
// counted loop and conditional skips
12
0203 0605 0801 14c0 8420 2300 a0fc 9001 0a77 8402
a001 0c42 1300 9001 0e11 a001 0a99 f000
4
001040 0005  001040 000a  001040 000f  001004 000f
00 00 00 00  01 00 00 00  0f 00 00 00  05 00 00 00
01 00 00 00  00 00 00 00  42 00 00 00  11 00 00 00
00
// end of list
0

/* tb.f */
design/cpu_pkg.sv
design/cpu_ifs.sv
design/cpu_regs.sv
design/cpu_alu.sv
design/cpu_result.sv
design/cpu_decode.sv
design/cpu_top.sv
tests/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the CPU testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_cpu -f tb.f -o sim_cpu

# the log decides pass or fail, not the exit status of the run
./obj_dir/sim_cpu 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi
